// File: hw/fm_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register front end configuration
// channel, operator and slot counts, busy
// length and global register addresses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

`define FM_NUM_CH       6
`define FM_NUM_OP       4
`define FM_NUM_SLOT     24  // ch * 4 + op
`define FM_BUSY_LEN     32  // clk_en pulses

`define FM_REG_LFO      8'h22
`define FM_REG_CLKA1    8'h24
`define FM_REG_CLKA2    8'h25
`define FM_REG_CLKB     8'h26
`define FM_REG_TIMER    8'h27
`define FM_REG_KON      8'h28
`define FM_REG_PCM      8'h2A
`define FM_REG_PCM_EN   8'h2B
`define FM_REG_DACTEST  8'h2C
`define FM_REG_CLK_N6   8'h2D
`define FM_REG_CLK_N3   8'h2E
`define FM_REG_CLK_N2   8'h2F

`endif

// File: hw/fm_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register types
// update kinds and the channel, operator
// and slot parameter entries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fm_pkg;

	// target of one decoded register update
	typedef enum logic [2:0] {
		UPD_NONE     = 3'd0,
		UPD_GLOBAL   = 3'd1,
		UPD_FNUM_LO  = 3'd2,
		UPD_BLOCK_HI = 3'd3,
		UPD_ALG_FB   = 3'd4,
		UPD_DT_MUL   = 3'd5,
		UPD_TL       = 3'd6,
		UPD_KEYON    = 3'd7
	} upd_kind_t;

	// per channel, 20 bits
	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  alg;
		logic [2:0]  fb;
	} ch_entry_t;

	// per slot, 14 bits
	typedef struct packed {
		logic [6:0] tl;
		logic [3:0] mul;
		logic [2:0] dt1;
	} op_entry_t;

	// what the synthesis engine sees for the current slot
	typedef struct packed {
		ch_entry_t ch;
		op_entry_t op;
		logic      keyon;
	} slot_param_t;

endpackage

// File: hw/fm_update_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register update channel
// one decoded write, decode to stores
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface fm_update_if;
	import fm_pkg::*;

	logic       valid;  // single cycle, no back-pressure
	upd_kind_t  kind;
	logic [7:0] sel;    // selected register
	logic [2:0] ch;     // {bank, sel[1:0]} or key-on code
	logic [1:0] op;
	logic [7:0] data;

	modport src (output valid, kind, sel, ch, op, data);
	modport dst (input valid, kind, sel, ch, op, data);

endinterface

// File: hw/fm_param_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM parameter store
// masked write, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fm_param_store #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 8
) (
	input  logic                       clk,
	input  logic                       we,
	input  logic [$clog2(DEPTH)-1:0]   waddr,
	input  logic [$bits(entry_t)-1:0]  wmask,
	input  entry_t                     wdata,
	input  logic [$clog2(DEPTH)-1:0]   raddr,
	output entry_t                     rdata
);

	entry_t mem [DEPTH];

	always_ff @(posedge clk) begin
		// only the masked fields change
		if (we)
			mem[waddr] <= entry_t'((mem[waddr] & ~wmask) | (wdata & wmask));
		rdata <= mem[raddr];
	end

endmodule

// File: hw/fm_bus_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM host bus decode
// write edge detect, register select,
// update classification and busy timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_bus_decode (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] din,
	input  logic [1:0] addr,
	input  logic       write,
	input  logic       clk_en,
	output logic       busy,
	fm_update_if.src   upd
);
	import fm_pkg::*;

	localparam int BUSY_W = $clog2(`FM_BUSY_LEN);

	logic              old_write;
	logic              wr_edge;
	logic [7:0]        sel_reg;
	upd_kind_t         kind_nxt;
	logic [2:0]        ch_nxt;
	logic              ch_ok;
	logic [BUSY_W-1:0] busy_cnt;

	assign wr_edge = write & ~old_write;

	always_comb begin
		kind_nxt = UPD_NONE;
		casez (sel_reg)
			8'hA0, 8'hA1, 8'hA2: kind_nxt = UPD_FNUM_LO;
			8'hA4, 8'hA5, 8'hA6: kind_nxt = UPD_BLOCK_HI;
			8'hB0, 8'hB1, 8'hB2: kind_nxt = UPD_ALG_FB;
			8'h3?:               kind_nxt = UPD_DT_MUL;
			8'h4?:               kind_nxt = UPD_TL;
			`FM_REG_KON:         kind_nxt = UPD_KEYON;
			`FM_REG_LFO, `FM_REG_CLKA1, `FM_REG_CLKA2, `FM_REG_CLKB,
			`FM_REG_TIMER, `FM_REG_PCM, `FM_REG_PCM_EN, `FM_REG_DACTEST,
			`FM_REG_CLK_N6, `FM_REG_CLK_N3, `FM_REG_CLK_N2:
				kind_nxt = UPD_GLOBAL;
			default: ;
		endcase
	end

	// key-on carries its channel in the data byte
	assign ch_nxt = (kind_nxt == UPD_KEYON) ? din[2:0] : {addr[1], sel_reg[1:0]};
	assign ch_ok  = (kind_nxt == UPD_GLOBAL) || (ch_nxt[1:0] != 2'd3);

	always_ff @(posedge clk) begin
		if (rst) begin
			old_write <= 1'b0;
			sel_reg   <= 8'h00;
			upd.valid <= 1'b0;
		end else begin
			old_write <= write;
			upd.valid <= wr_edge & addr[0] & (kind_nxt != UPD_NONE) & ch_ok;
			if (wr_edge && !addr[0])
				sel_reg <= din;  // address phase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_edge && addr[0]) begin
			upd.kind <= kind_nxt;
			upd.sel  <= sel_reg;
			upd.ch   <= ch_nxt;
			upd.op   <= sel_reg[3:2];
			upd.data <= din;
		end
	end

	// busy is advisory, counts synthesis clock enables
	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			busy_cnt <= '0;
		end else if (wr_edge && addr[0]) begin
			busy     <= 1'b1;
			busy_cnt <= '0;
		end else if (clk_en && busy) begin
			if (busy_cnt == BUSY_W'(`FM_BUSY_LEN - 1))
				busy <= 1'b0;
			busy_cnt <= busy_cnt + 1'b1;
		end
	end

	a_valid_single: assert property (@(posedge clk) disable iff (rst)
		upd.valid |=> !upd.valid);

endmodule

// File: hw/fm_global_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM global registers
// timers, LFO, PCM and the clk_en
// prescaler
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_global_regs (
	input  logic       clk,
	input  logic       rst,
	input  logic       cen,
	fm_update_if.dst   upd,
	output logic       clk_en,
	output logic [9:0] value_a,
	output logic [7:0] value_b,
	output logic       load_a,
	output logic       load_b,
	output logic       irq_en_a,
	output logic       irq_en_b,
	output logic       clr_flag_a,
	output logic       clr_flag_b,
	output logic       lfo_en,
	output logic [2:0] lfo_freq,
	output logic [8:0] pcm,
	output logic       pcm_en
);
	import fm_pkg::*;

	logic [2:0] div_cnt;
	logic [2:0] div_lim;  // ratio minus one
	logic       g_wr;
	logic       lim_wr;

	assign g_wr   = upd.valid && (upd.kind == UPD_GLOBAL);
	assign lim_wr = g_wr && (upd.sel == `FM_REG_CLK_N6 || upd.sel == `FM_REG_CLK_N3 ||
		upd.sel == `FM_REG_CLK_N2);

	assign clk_en = cen && (div_cnt == div_lim);

	always_ff @(posedge clk) begin
		if (rst)
			div_cnt <= 3'd0;
		else if (lim_wr)
			div_cnt <= 3'd0;  // restart on a new ratio
		else if (cen)
			div_cnt <= (div_cnt == div_lim) ? 3'd0 : div_cnt + 3'd1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			div_lim  <= 3'd5;
			value_a  <= 10'd0;
			value_b  <= 8'd0;
			{clr_flag_b, clr_flag_a, irq_en_b, irq_en_a, load_b, load_a} <= 6'd0;
			lfo_en   <= 1'b0;
			lfo_freq <= 3'd0;
			pcm      <= 9'd0;
			pcm_en   <= 1'b0;
		end else begin
			if (clk_en)
				{clr_flag_b, clr_flag_a} <= 2'd0;  // one-shot
			if (g_wr) begin
				case (upd.sel)
					`FM_REG_CLKA1:   value_a[9:2] <= upd.data;
					`FM_REG_CLKA2:   value_a[1:0] <= upd.data[1:0];
					`FM_REG_CLKB:    value_b <= upd.data;
					`FM_REG_TIMER:
						{clr_flag_b, clr_flag_a, irq_en_b, irq_en_a, load_b, load_a} <=
							upd.data[5:0];
					`FM_REG_LFO:     {lfo_en, lfo_freq} <= upd.data[3:0];
					`FM_REG_PCM:     pcm[8:1] <= upd.data;
					`FM_REG_DACTEST: pcm[0] <= upd.data[3];
					`FM_REG_PCM_EN:  pcm_en <= upd.data[7];
					`FM_REG_CLK_N6:  div_lim <= 3'd5;
					`FM_REG_CLK_N3:  div_lim <= 3'd2;
					`FM_REG_CLK_N2:  div_lim <= 3'd1;
					default: ;
				endcase
			end
		end
	end

	a_div_in_range: assert property (@(posedge clk) disable iff (rst)
		div_cnt <= div_lim);

endmodule

// File: hw/fm_slot_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM slot sequencer
// channel and operator stores, key-on
// bits and the 24 slot scan
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "fm_config.svh"

module fm_slot_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                clk_en,
	fm_update_if.dst            upd,
	output logic [4:0]          slot,
	output fm_pkg::slot_param_t param
);
	import fm_pkg::*;

	logic [2:0]              ch_lin;
	logic                    ch_we;
	logic                    op_we;
	ch_entry_t               ch_wdata;
	ch_entry_t               ch_wmask;
	op_entry_t               op_wdata;
	op_entry_t               op_wmask;
	logic [4:0]              slot_nxt;
	logic [4:0]              rd_slot;
	logic [`FM_NUM_SLOT-1:0] kon;
	logic                    kon_q;

	// bank 1 channels follow the three of bank 0
	assign ch_lin = upd.ch[2] ? {1'b0, upd.ch[1:0]} + 3'd3 : {1'b0, upd.ch[1:0]};

	always_comb begin
		ch_wdata = '0;
		ch_wmask = '0;
		op_wdata = '0;
		op_wmask = '0;
		ch_we    = 1'b0;
		op_we    = 1'b0;
		case (upd.kind)
			UPD_FNUM_LO: begin
				ch_we              = upd.valid;
				ch_wdata.fnum[7:0] = upd.data;
				ch_wmask.fnum[7:0] = 8'hFF;
			end
			UPD_BLOCK_HI: begin
				ch_we                    = upd.valid;
				{ch_wdata.block, ch_wdata.fnum[10:8]} = upd.data[5:0];
				{ch_wmask.block, ch_wmask.fnum[10:8]} = 6'h3F;
			end
			UPD_ALG_FB: begin
				ch_we                    = upd.valid;
				{ch_wdata.fb, ch_wdata.alg} = upd.data[5:0];
				{ch_wmask.fb, ch_wmask.alg} = 6'h3F;
			end
			UPD_DT_MUL: begin
				op_we                      = upd.valid;
				{op_wdata.dt1, op_wdata.mul} = upd.data[6:0];
				{op_wmask.dt1, op_wmask.mul} = 7'h7F;
			end
			UPD_TL: begin
				op_we       = upd.valid;
				op_wdata.tl = upd.data[6:0];
				op_wmask.tl = 7'h7F;
			end
			default: ;
		endcase
	end

	assign slot_nxt = (slot == 5'(`FM_NUM_SLOT - 1)) ? 5'd0 : slot + 5'd1;
	assign rd_slot  = clk_en ? slot_nxt : slot;  // read ahead so data lands with slot

	fm_param_store #(.entry_t(ch_entry_t), .DEPTH(`FM_NUM_CH)) u_ch_store (
		.clk(clk), .we(ch_we), .waddr(ch_lin), .wmask(ch_wmask), .wdata(ch_wdata),
		.raddr(rd_slot[4:2]), .rdata(param.ch)
	);

	fm_param_store #(.entry_t(op_entry_t), .DEPTH(`FM_NUM_SLOT)) u_op_store (
		.clk(clk), .we(op_we), .waddr({ch_lin, upd.op}), .wmask(op_wmask),
		.wdata(op_wdata), .raddr(rd_slot), .rdata(param.op)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			kon   <= '0;
			slot  <= 5'd0;
			kon_q <= 1'b0;
		end else begin
			if (upd.valid && upd.kind == UPD_KEYON)
				for (int i = 0; i < `FM_NUM_OP; i++)
					kon[{ch_lin, 2'(i)}] <= upd.data[4 + i];  // mask bit per op
			if (clk_en)
				slot <= slot_nxt;
			kon_q <= kon[rd_slot];
		end
	end

	assign param.keyon = kon_q;

	a_slot_range: assert property (@(posedge clk) disable iff (rst)
		slot < 5'(`FM_NUM_SLOT));

endmodule

// File: hw/fm_mmr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register front end, top level
// bus decode, globals and slot scan
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fm_mmr (
	input  logic        clk,
	input  logic        rst,
	input  logic        cen,
	input  logic [7:0]  din,
	input  logic [1:0]  addr,
	input  logic        write,
	output logic        busy,
	output logic        clk_en,
	output logic [9:0]  value_a,
	output logic [7:0]  value_b,
	output logic        load_a,
	output logic        load_b,
	output logic        irq_en_a,
	output logic        irq_en_b,
	output logic        clr_flag_a,
	output logic        clr_flag_b,
	output logic        lfo_en,
	output logic [2:0]  lfo_freq,
	output logic [8:0]  pcm,
	output logic        pcm_en,
	output logic [4:0]  slot,
	output logic [10:0] fnum,
	output logic [2:0]  block,
	output logic [2:0]  alg,
	output logic [2:0]  fb,
	output logic [6:0]  tl,
	output logic [3:0]  mul,
	output logic [2:0]  dt1,
	output logic        keyon
);
	import fm_pkg::*;

	slot_param_t param;

	fm_update_if upd ();

	fm_bus_decode u_decode (
		.clk(clk), .rst(rst), .din(din), .addr(addr), .write(write),
		.clk_en(clk_en), .busy(busy), .upd(upd.src)
	);

	fm_global_regs u_globals (
		.clk(clk), .rst(rst), .cen(cen), .upd(upd.dst), .clk_en(clk_en),
		.value_a(value_a), .value_b(value_b), .load_a(load_a), .load_b(load_b),
		.irq_en_a(irq_en_a), .irq_en_b(irq_en_b),
		.clr_flag_a(clr_flag_a), .clr_flag_b(clr_flag_b),
		.lfo_en(lfo_en), .lfo_freq(lfo_freq), .pcm(pcm), .pcm_en(pcm_en)
	);

	fm_slot_sequencer u_seq (
		.clk(clk), .rst(rst), .clk_en(clk_en), .upd(upd.dst),
		.slot(slot), .param(param)
	);

	// slot fields for the synthesis engine
	assign fnum  = param.ch.fnum;
	assign block = param.ch.block;
	assign alg   = param.ch.alg;
	assign fb    = param.ch.fb;
	assign tl    = param.op.tl;
	assign mul   = param.op.mul;
	assign dt1   = param.op.dt1;
	assign keyon = param.keyon;

endmodule

// File: bench/tb_fm_mmr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM register front end testbench
// runs the command file against fm_mmr
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "fm_config.svh"

module tb_fm_mmr;

	logic        clk;
	logic        rst;
	logic        cen;
	logic [7:0]  din;
	logic [1:0]  addr;
	logic        write;
	logic        busy, clk_en, load_a, load_b, irq_en_a, irq_en_b;
	logic        clr_flag_a, clr_flag_b, lfo_en, pcm_en, keyon;
	logic [9:0]  value_a;
	logic [7:0]  value_b;
	logic [2:0]  lfo_freq, block, alg, fb, dt1;
	logic [8:0]  pcm;
	logic [4:0]  slot;
	logic [10:0] fnum;
	logic [6:0]  tl;
	logic [3:0]  mul;

	string       kinds [$];
	string       names [$];
	logic [31:0] vals [$];
	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	int          limit = 1000;
	int          since_wr = 0;  // cycles since the last write edge
	int          busy_pulses = 0;
	bit          busy_seen = 1'b0;
	bit          clr_seen = 1'b0;
	bit          write_prev = 1'b0;

	// expected register state kept from the writes
	logic [7:0]              sel_exp = 8'h00;
	logic [7:0]              timer_exp = 8'h00;
	logic [`FM_NUM_SLOT-1:0] kon_exp = '0;

	fm_mmr dut0 (.*);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, %0d checks, %0d errors", cycles, checks, errors);
			$display("Simulation failed");
			$finish;
		end
	end

	// waits one negedge with outputs settled and tracks busy and flag activity
	task automatic tick();
		@(negedge clk);
		if (write && !write_prev) begin
			since_wr  = 0;
			busy_seen = 1'b0;
			clr_seen  = 1'b0;
			if (addr[0])
				busy_pulses = 0;  // data write restarts busy
		end else begin
			since_wr++;
		end
		write_prev = write;
		if (busy && since_wr >= 1 && since_wr <= 2)
			busy_seen = 1'b1;
		if (busy && clk_en && since_wr > 0)
			busy_pulses++;
		if (clr_flag_a)
			clr_seen = 1'b1;
	endtask

	task automatic bus_write(logic [1:0] a, logic [7:0] d);
		@(posedge clk);
		addr  <= a;
		din   <= d;
		write <= 1'b1;
		tick();
		@(posedge clk);
		tick();
		@(posedge clk);
		write <= 1'b0;
		tick();
		@(posedge clk);
		tick();
	endtask

	// follows the register map for the selected register, timer byte and key-on bits
	task automatic model_write(logic [1:0] a, logic [7:0] d);
		logic [2:0] ch;
		if (!a[0]) begin
			sel_exp = d;
		end else if (sel_exp == `FM_REG_TIMER) begin
			timer_exp = d;
		end else if (sel_exp == `FM_REG_KON && d[1:0] != 2'd3) begin
			ch = d[2] ? d[2:0] - 3'd1 : d[2:0];  // codes 4-6 are channels 3-5
			kon_exp[{ch, 2'd0} +: 4] = d[7:4];
		end
	endtask

	task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			$display("ERROR %s got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_global(string name, logic [31:0] exp);
		logic [31:0] got;
		int          gap;
		while (since_wr < 8)
			tick();
		case (name)
			"value_a":    got = 32'(value_a);
			"value_b":    got = 32'(value_b);
			"lfo_en":     got = 32'(lfo_en);
			"lfo_freq":   got = 32'(lfo_freq);
			"pcm":        got = 32'(pcm);
			"pcm_en":     got = 32'(pcm_en);
			"load_a":     got = 32'(load_a);
			"irq_en_a":   got = 32'(irq_en_a);
			"clr_flag_a": got = 32'(clr_flag_a);
			"busy_seen":  got = 32'(busy_seen);
			"clr_a_seen": got = 32'(clr_seen);
			"busy_len": begin
				while (busy)
					tick();
				got = busy_pulses;
			end
			"clk_en_gap": begin
				while (!clk_en)
					tick();
				gap = 0;
				do begin
					tick();
					gap++;
				end while (!clk_en);
				got = gap;
			end
			default: begin
				$display("command file names an unknown output: %s", name);
				errors++;
				return;
			end
		endcase
		compare_value(name, got, exp);
		// timer b bits follow the last timer write
		if (name == "load_a")
			compare_value("load_b", 32'(load_b), 32'(timer_exp[1]));
		if (name == "irq_en_a")
			compare_value("irq_en_b", 32'(irq_en_b), 32'(timer_exp[3]));
		if (name == "clr_flag_a")
			compare_value("clr_flag_b", 32'(clr_flag_b), 32'd0);
	endtask

	// waits for the slot, then compares every field
	task automatic verify_slot();
		logic [31:0] e [9];
		for (int i = 0; i < 9; i++)
			e[i] = vals.pop_front();
		while (since_wr < 8 || 32'(slot) != e[0])
			tick();
		compare_value($sformatf("slot %0d fnum", e[0]), 32'(fnum), e[1]);
		compare_value($sformatf("slot %0d block", e[0]), 32'(block), e[2]);
		compare_value($sformatf("slot %0d alg", e[0]), 32'(alg), e[3]);
		compare_value($sformatf("slot %0d fb", e[0]), 32'(fb), e[4]);
		compare_value($sformatf("slot %0d tl", e[0]), 32'(tl), e[5]);
		compare_value($sformatf("slot %0d mul", e[0]), 32'(mul), e[6]);
		compare_value($sformatf("slot %0d dt1", e[0]), 32'(dt1), e[7]);
		compare_value($sformatf("slot %0d keyon", e[0]), 32'(keyon), e[8]);
	endtask

	// one full slot round, every key-on bit against the expected set
	task automatic scan_keyon();
		logic [4:0] last;
		int         seen;
		while (since_wr < 8)
			tick();
		last = slot;
		seen = 1;
		compare_value($sformatf("slot %0d keyon", slot), 32'(keyon),
			32'(kon_exp[slot]));
		while (seen < `FM_NUM_SLOT) begin
			tick();
			if (slot != last) begin
				last = slot;
				seen++;
				compare_value($sformatf("slot %0d keyon", slot), 32'(keyon),
					32'(kon_exp[slot]));
			end
		end
	endtask

	task automatic read_commands();
		int          fd;
		int          n;
		string       tok;
		string       line;
		string       name;
		logic [31:0] x;
		fd = $fopen("bench/fm_mmr_input.txt", "r");
		if (fd == 0) begin
			$display("could not open the command file");
			errors++;
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				n = $fgets(line, fd);  // comment line
			end else if (tok == "G") begin
				n = $fscanf(fd, "%s %h", name, x);
				names.push_back(name);
				vals.push_back(x);
				kinds.push_back(tok);
			end else if (tok == "W" || tok == "S") begin
				for (int i = 0; i < (tok == "W" ? 2 : 9); i++) begin
					n = $fscanf(fd, "%h", x);
					vals.push_back(x);
				end
				kinds.push_back(tok);
			end else begin
				$display("command file holds an unknown command: %s", tok);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	initial begin
		string       kind;
		logic [31:0] a;
		logic [31:0] d;
		clk   = 1'b0;
		rst   = 1'b1;
		cen   = 1'b1;
		din   = 8'h00;
		addr  = 2'd0;
		write = 1'b0;
		read_commands();
		limit = kinds.size() * 200 + 1000;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		while (kinds.size() > 0) begin
			kind = kinds.pop_front();
			if (kind == "W") begin
				a = vals.pop_front();
				d = vals.pop_front();
				bus_write(a[1:0], d[7:0]);
				model_write(a[1:0], d[7:0]);
				if (a[0] && sel_exp == `FM_REG_KON)
					scan_keyon();
			end else if (kind == "G") begin
				check_global(names.pop_front(), vals.pop_front());
			end else begin
				verify_slot();
			end
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: fm_mmr.f
+incdir+hw
hw/fm_pkg.sv
hw/fm_update_if.sv
hw/fm_param_store.sv
hw/fm_bus_decode.sv
hw/fm_global_regs.sv
hw/fm_slot_sequencer.sv
hw/fm_mmr.sv
bench/tb_fm_mmr.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_fm_mmr
FILELIST = fm_mmr.f
LOG      = sim.log
FAIL_MSG = Simulation failed
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove obj_dir and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "run ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: bench/fm_mmr_input.txt
# W addr data | G name value | S slot fnum block alg fb tl mul dt1 keyon (all hex)
# G names: outputs, or busy_seen, busy_len, clk_en_gap, clr_a_seen
W 0 22
G busy_seen 0
W 1 0D
G busy_seen 1
G busy_len 20
G lfo_en 1
G lfo_freq 5
W 0 24
W 1 A5
W 0 25
W 1 03
G value_a 297
W 0 26
W 1 C3
G value_b C3
W 0 2A
W 1 5B
W 0 2C
W 1 08
G pcm B7
W 0 2B
W 1 80
G pcm_en 1
W 0 2E
W 1 00
G clk_en_gap 3
W 0 2F
W 1 00
G clk_en_gap 2
W 0 27
W 1 15
G clr_a_seen 1
G clr_flag_a 0
G irq_en_a 1
G load_a 1
W 0 2D
W 1 00
G clk_en_gap 6
W 0 A5
W 1 23
W 0 A1
W 1 9C
W 0 B1
W 1 2E
W 0 39
W 1 57
W 0 49
W 1 1F
S 06 39C 4 6 5 1F 7 5 0
W 2 A5
W 3 3A
W 2 A1
W 3 11
W 2 B1
W 3 07
W 2 3D
W 3 62
W 2 4D
W 3 7F
S 13 211 7 7 0 7F 2 6 0
W 0 A1
W 1 44
W 0 49
W 1 05
W 0 31
W 1 13
W 0 41
W 1 22
S 06 344 4 6 5 05 7 5 0
S 04 344 4 6 5 22 3 1 0
W 0 28
W 1 41
W 1 85
S 06 344 4 6 5 05 7 5 1
S 04 344 4 6 5 22 3 1 0
S 13 211 7 7 0 7F 2 6 1
W 1 F3
S 06 344 4 6 5 05 7 5 1
W 1 01
S 06 344 4 6 5 05 7 5 0
S 13 211 7 7 0 7F 2 6 1
